// File: sources.f
+incdir+include
src/pwm_pkg.sv
src/apb_pkg.sv
src/addsub.sv
src/pwm_preconditioner.sv
src/pwm_regfile.sv
src/pwm_output.sv
src/pwm_top.sv
tb/tb_pwm_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pwm_top
RTL_TOP   ?= pwm_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_pwm_top.sv
/*
  testbench for the PWM subsystem top
  APB access tasks, edge and output reference model, compare tasks, watchdog
*/
`timescale 1ns/10ps
`default_nettype none
`include "pwm_settings.svh"

module tb_pwm_top;

  localparam int N_CH = `PWM_CHANNELS;
  localparam int NUM_CASES = 6;
  localparam logic [7:0] CTRL_ADDR = 8'h80;
  localparam int TIMEOUT_CYCLES = NUM_CASES * 3 * `PWM_PERIOD + 4096;

  typedef struct packed {
    pwm_pkg::drive_t [N_CH-1:0] drv;
    logic                       busy_err; // poke the DUT while it streams
  } case_t;

  logic CLK;
  logic rst_n;
  apb_pkg::apb_req_t apb_req;
  apb_pkg::apb_rsp_t apb_rsp;
  logic [N_CH-1:0] pwm_out;
  logic sync;

  case_t cases [NUM_CASES];
  int errors;
  int checks;

  pwm_top dut0 (
    .CLK(CLK),
    .rst_n(rst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .pwm_out(pwm_out),
    .sync(sync)
  );

  always #50 CLK = ~CLK;

  initial begin
    #(TIMEOUT_CYCLES * 100);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("errors: %0d in %0d checks", errors, checks);
    $display("CHECKS FAILED");
    $finish;
  end

  // edge rule, folded once into one period
  function automatic pwm_pkg::edge_t ref_edge(input pwm_pkg::drive_t d);
    int half, base, rise, fall;
    pwm_pkg::edge_t e;
    half = int'(d.duty) >> 1;
    base = `PWM_PERIOD - int'(d.phase);
    rise = base - half;
    fall = base + half + int'(d.duty[0]);
    if (rise < 0) rise += `PWM_PERIOD;
    else if (rise >= `PWM_PERIOD) rise -= `PWM_PERIOD;
    if (fall >= `PWM_PERIOD) fall -= `PWM_PERIOD;
    e.rise = rise[`PWM_WIDTH-1:0];
    e.fall = fall[`PWM_WIDTH-1:0];
    return e;
  endfunction

  function automatic logic [N_CH-1:0] ref_out(input case_t c, input int t);
    logic [N_CH-1:0] v;
    pwm_pkg::edge_t e;
    for (int i = 0; i < N_CH; i++) begin
      e = ref_edge(c.drv[i]);
      if (e.rise <= e.fall) v[i] = (t >= int'(e.rise)) && (t < int'(e.fall));
      else v[i] = (t >= int'(e.rise)) || (t < int'(e.fall)); // wraps past period end
    end
    return v;
  endfunction

  task automatic check_word(input string name, input pwm_pkg::reg_word_u exp,
                            input pwm_pkg::reg_word_u got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s expected 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  task automatic check_out(input string name, input logic [N_CH-1:0] exp,
                           input logic [N_CH-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s expected 0x%02h got 0x%02h", name, exp, got);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s expected 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  task automatic check_sync(input int t, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail sync at cycle %0d expected 0x%0h got 0x%0h", t, exp, got);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge CLK);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    @(negedge CLK);
    err = apb_rsp.pslverr;
    check_err("pready", 1'b1, apb_rsp.pready);
    @(posedge CLK);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output pwm_pkg::reg_word_u data,
                          output logic err);
    @(posedge CLK);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    @(negedge CLK);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_err("pready", 1'b1, apb_rsp.pready);
    @(posedge CLK);
    apb_req <= '0;
  endtask

  function automatic pwm_pkg::reg_word_u drive_word(input pwm_pkg::drive_t d);
    pwm_pkg::reg_word_u w;
    w = '0;
    w.drv.duty  = d.duty;
    w.drv.phase = d.phase;
    return w;
  endfunction

  task automatic write_drive(input int ch, input pwm_pkg::drive_t d, input logic exp_err);
    logic err;
    apb_write(8'(ch * 4), drive_word(d), err);
    check_err($sformatf("pslverr ch%0d write", ch), exp_err, err);
  endtask

  task automatic read_drive(input int ch, input pwm_pkg::drive_t d);
    pwm_pkg::reg_word_u w;
    logic err;
    apb_read(8'(ch * 4), w, err);
    check_word($sformatf("ch%0d readback", ch), drive_word(d), w);
    check_err($sformatf("pslverr ch%0d read", ch), 1'b0, err);
  endtask

  task automatic commit(input logic exp_err);
    pwm_pkg::reg_word_u w;
    logic err;
    w = '0;
    w.ctrl.update = 1'b1;
    apb_write(CTRL_ADDR, w, err);
    check_err("pslverr commit", exp_err, err);
  endtask

  task automatic wait_idle();
    pwm_pkg::reg_word_u w;
    logic err;
    do begin
      apb_read(CTRL_ADDR, w, err);
    end while (w.ctrl.update);
  endtask

  task automatic wait_sync();
    do @(negedge CLK); while (!sync);
  endtask

  // pwm_out trails the count by one cycle
  task automatic check_period(input case_t c);
    wait_sync();
    for (int t = 0; t < `PWM_PERIOD; t++) begin
      @(negedge CLK);
      check_out($sformatf("pwm_out t=%0d", t), ref_out(c, t), pwm_out);
    end
  endtask

  task automatic reset_checks();
    pwm_pkg::reg_word_u w;
    logic err;
    for (int i = 0; i < 2 * `PWM_PERIOD; i++) begin
      @(negedge CLK);
      check_sync(i, (i % `PWM_PERIOD) == 0, sync);
      check_out("pwm_out after reset", '0, pwm_out);
    end
    apb_read(CTRL_ADDR, w, err);
    check_word("ctrl after reset", '0, w);
    check_err("pslverr ctrl read", 1'b0, err);
  endtask

  task automatic map_checks();
    pwm_pkg::reg_word_u w;
    logic err;
    apb_write(8'h40, 32'h0001_0001, err);
    check_err("pslverr write 0x40", 1'b1, err);
    apb_read(8'h84, w, err);
    check_err("pslverr read 0x84", 1'b1, err);
    apb_read(8'h06, w, err); // misaligned
    check_err("pslverr read 0x06", 1'b1, err);
    apb_read(8'h1c, w, err);
    check_err("pslverr read 0x1c", 1'b0, err);
  endtask

  task automatic run_case(input case_t c);
    pwm_pkg::drive_t junk;
    for (int ch = 0; ch < N_CH; ch++) write_drive(ch, c.drv[ch], 1'b0);
    for (int ch = 0; ch < N_CH; ch++) read_drive(ch, c.drv[ch]);
    commit(1'b0);
    if (c.busy_err) begin
      junk = ~c.drv[0];
      write_drive(0, junk, 1'b1);
      commit(1'b1);
    end
    wait_idle();
    if (c.busy_err) read_drive(0, c.drv[0]); // rejected write left no trace
    check_period(c);
  endtask

  task automatic fill_table();
    void'($urandom(32'h93d13113));
    cases[0].busy_err = 1'b0;
    cases[0].drv[0] = '{duty: 9'd0,   phase: 9'd0};
    cases[0].drv[1] = '{duty: 9'd511, phase: 9'd0};
    cases[0].drv[2] = '{duty: 9'd256, phase: 9'd0};
    cases[0].drv[3] = '{duty: 9'd100, phase: 9'd500};
    cases[0].drv[4] = '{duty: 9'd511, phase: 9'd511};
    cases[0].drv[5] = '{duty: 9'd1,   phase: 9'd1};
    cases[0].drv[6] = '{duty: 9'd300, phase: 9'd200};
    cases[0].drv[7] = '{duty: 9'd37,  phase: 9'd450};
    cases[1].busy_err = 1'b1;
    cases[1].drv[0] = '{duty: 9'd200, phase: 9'd0};
    cases[1].drv[1] = '{duty: 9'd0,   phase: 9'd300};
    cases[1].drv[2] = '{duty: 9'd511, phase: 9'd256};
    cases[1].drv[3] = '{duty: 9'd2,   phase: 9'd510};
    cases[1].drv[4] = '{duty: 9'd400, phase: 9'd480};
    cases[1].drv[5] = '{duty: 9'd128, phase: 9'd64};
    cases[1].drv[6] = '{duty: 9'd9,   phase: 9'd511};
    cases[1].drv[7] = '{duty: 9'd300, phase: 9'd1};
    // back-to-back random sets
    for (int k = 2; k < NUM_CASES; k++) begin
      cases[k].busy_err = (k == 4);
      for (int ch = 0; ch < N_CH; ch++) begin
        cases[k].drv[ch].duty  = 9'($urandom);
        cases[k].drv[ch].phase = 9'($urandom);
      end
    end
  endtask

  initial begin
    CLK     = 1'b0;
    rst_n   = 1'b0;
    apb_req = '0;
    errors  = 0;
    checks  = 0;
    fill_table();
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;
    reset_checks();
    map_checks();
    for (int k = 0; k < NUM_CASES; k++) run_case(cases[k]);
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/pwm_top.sv
/*
  PWM subsystem top
  register file, preconditioner and output stage
*/
`timescale 1ns/10ps
`default_nettype none
`include "pwm_settings.svh"

module pwm_top (
  input  var logic              CLK,
  input  var logic              rst_n,
  input  var apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t     apb_rsp,
  output logic [`PWM_CHANNELS-1:0] pwm_out,
  output logic                  sync
);

  logic stream_valid;
  pwm_pkg::drive_t stream_drive;
  pwm_pkg::edge_t edges [`PWM_CHANNELS];
  logic done;

  pwm_regfile u_regfile (
    .CLK(CLK),
    .rst_n(rst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .done(done),
    .stream_valid(stream_valid),
    .stream_drive(stream_drive)
  );

  pwm_preconditioner u_precond (
    .CLK(CLK),
    .rst_n(rst_n),
    .stream_valid(stream_valid),
    .stream_drive(stream_drive),
    .edges(edges),
    .done(done)
  );

  pwm_output u_output (
    .CLK(CLK),
    .rst_n(rst_n),
    .edges(edges),
    .done(done),
    .pwm_out(pwm_out),
    .sync(sync)
  );

endmodule

`default_nettype wire

// File: src/pwm_output.sv
/*
  carrier period counter and per-channel pulse outputs
  new edge tables are swapped in only at the period boundary
*/
`timescale 1ns/10ps
`default_nettype none
`include "pwm_settings.svh"

module pwm_output (
  input  var logic           CLK,
  input  var logic           rst_n,
  input  var pwm_pkg::edge_t edges [`PWM_CHANNELS],
  input  var logic           done,
  output logic [`PWM_CHANNELS-1:0] pwm_out,
  output logic               sync
);

  localparam int W = `PWM_WIDTH;

  logic [W-1:0] cnt;
  logic wrap, pend_valid;
  pwm_pkg::edge_t [`PWM_CHANNELS-1:0] incoming, pending, active;

  function automatic logic in_pulse(input logic [W-1:0] t, input pwm_pkg::edge_t e);
    if (e.rise <= e.fall) return (t >= e.rise) && (t < e.fall);
    return (t >= e.rise) || (t < e.fall); // pulse wraps the period end
  endfunction

  for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : gen_in
    assign incoming[i] = edges[i];
  end

  assign wrap = cnt == W'(`PWM_PERIOD - 1);
  assign sync = cnt == '0;

  always_ff @(posedge CLK) begin
    if (!rst_n) cnt <= '0;
    else cnt <= wrap ? '0 : cnt + 1'b1;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pending    <= '0;
      active     <= '0;
      pend_valid <= 1'b0;
    end else if (wrap) begin
      pend_valid <= 1'b0;
      if (done) active <= incoming;
      else if (pend_valid) active <= pending;
    end else if (done) begin
      pending    <= incoming;
      pend_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pwm_out <= '0;
    end else begin
      for (int i = 0; i < `PWM_CHANNELS; i++) pwm_out[i] <= in_pulse(cnt, active[i]);
    end
  end

  active_at_boundary: assert property (@(posedge CLK) disable iff (!rst_n)
    !$stable(active) |-> cnt == '0);

endmodule

`default_nettype wire

// File: src/pwm_regfile.sv
/*
  APB slave with per-channel drive registers and control register
  commit streams all channels to the preconditioner, one per clock
*/
`timescale 1ns/10ps
`default_nettype none
`include "pwm_settings.svh"

module pwm_regfile (
  input  var logic              CLK,
  input  var logic              rst_n,
  input  var apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t     apb_rsp,
  input  var logic              done,
  output logic                  stream_valid,
  output pwm_pkg::drive_t       stream_drive
);

  localparam int CH_W = $clog2(`PWM_CHANNELS);
  localparam logic [7:0] CTRL_ADDR = 8'h80;

  pwm_pkg::drive_t drive_mem [`PWM_CHANNELS];
  pwm_pkg::reg_word_u wr_word, rd_word;
  logic access, is_chan, is_ctrl, commit_req, err, wr_ok, busy;
  logic [CH_W-1:0] ch_sel, stream_idx;

  assign access     = apb_req.psel && apb_req.penable;
  assign ch_sel     = apb_req.paddr[CH_W+1:2];
  assign is_chan    = (apb_req.paddr[1:0] == 2'b00) && (apb_req.paddr[7:2] < 6'(`PWM_CHANNELS));
  assign is_ctrl    = apb_req.paddr == CTRL_ADDR;
  assign wr_word    = apb_req.pwdata;
  assign commit_req = is_ctrl && wr_word.ctrl.update;

  // unmapped, or touching the set while it is being streamed
  assign err   = access && (!(is_chan || is_ctrl) ||
                            (apb_req.pwrite && busy && (is_chan || commit_req)));
  assign wr_ok = access && apb_req.pwrite && !err;

  always_comb begin
    rd_word = '0;
    if (is_chan) begin
      rd_word.drv.duty  = drive_mem[ch_sel].duty;
      rd_word.drv.phase = drive_mem[ch_sel].phase;
    end else if (is_ctrl) begin
      rd_word.ctrl.update = busy;
    end
  end

  assign apb_rsp = '{pready: 1'b1, pslverr: err,
                     prdata: (access && !apb_req.pwrite) ? rd_word : '0};

  always_ff @(posedge CLK) begin
    if (wr_ok && is_chan) begin
      drive_mem[ch_sel] <= '{duty: wr_word.drv.duty, phase: wr_word.drv.phase};
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      stream_valid <= 1'b0;
      stream_idx   <= '0;
    end else begin
      if (wr_ok && commit_req) begin
        busy         <= 1'b1;
        stream_valid <= 1'b1;
        stream_idx   <= '0;
      end else if (stream_valid) begin
        stream_idx <= stream_idx + 1'b1;
        if (stream_idx == CH_W'(`PWM_CHANNELS - 1)) stream_valid <= 1'b0;
      end
      if (done) busy <= 1'b0; // table latched downstream
    end
  end

  assign stream_drive = drive_mem[stream_idx];

  apb_setup_first: assert property (@(posedge CLK) disable iff (!rst_n)
    access |-> $past(apb_req.psel && !apb_req.penable));

  stream_while_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    stream_valid |-> busy);

endmodule

`default_nettype wire

// File: src/pwm_preconditioner.sv
/*
  duty/phase to rise/fall edge pipeline
  three addsub steps, fold into one period, latched edge table
*/
`timescale 1ns/10ps
`default_nettype none
`include "pwm_settings.svh"

module pwm_preconditioner (
  input  var logic           CLK,
  input  var logic           rst_n,
  input  var logic           stream_valid,
  input  var pwm_pkg::drive_t stream_drive,
  output pwm_pkg::edge_t     edges [`PWM_CHANNELS],
  output logic               done
);

  localparam int W = `PWM_WIDTH;
  localparam int AW = W + 2; // room for sign and one carry
  localparam int LAT = `PWM_ADDSUB_LATENCY;
  localparam int CH_W = $clog2(`PWM_CHANNELS);
  localparam int CNT_W = $clog2(`PWM_CHANNELS + 3 * (LAT + 1)) + 1;
  localparam logic signed [AW-1:0] PERIOD = AW'(`PWM_PERIOD);

  typedef enum logic [1:0] {ST_WAIT, ST_RUN, ST_DONE} state_t;

  state_t state;
  logic [CNT_W-1:0] cnt, lr_cnt, fold_cnt, set_cnt;
  logic store_en;

  logic [W-1:0] duty_dly [LAT+2];
  logic [W-1:0] phase_q;
  pwm_pkg::edge_t edge_buf [`PWM_CHANNELS];

  logic signed [AW-1:0] b_phase, s_phase;
  logic signed [AW-1:0] a_duty, b_duty, s_duty;
  logic signed [AW-1:0] a_rise, b_rise, s_rise;
  logic signed [AW-1:0] a_fall, b_fall, s_fall;
  logic signed [AW-1:0] a_fold_rise, b_fold_rise, s_fold_rise;
  logic signed [AW-1:0] a_fold_fall, b_fold_fall, s_fold_fall;
  logic fold_rise_add;

  // step 1: base = period - phase, half + lsb of duty
  addsub #(.WIDTH(AW)) u_sub_phase (
    .CLK(CLK), .add(1'b0), .a(PERIOD), .b(b_phase), .s(s_phase));
  addsub #(.WIDTH(AW)) u_add_duty (
    .CLK(CLK), .add(1'b1), .a(a_duty), .b(b_duty), .s(s_duty));
  // step 2: raw rise and fall
  addsub #(.WIDTH(AW)) u_sub_rise (
    .CLK(CLK), .add(1'b0), .a(a_rise), .b(b_rise), .s(s_rise));
  addsub #(.WIDTH(AW)) u_add_fall (
    .CLK(CLK), .add(1'b1), .a(a_fall), .b(b_fall), .s(s_fall));
  // step 3: fold into 0..period-1
  addsub #(.WIDTH(AW)) u_fold_rise (
    .CLK(CLK), .add(fold_rise_add), .a(a_fold_rise), .b(b_fold_rise), .s(s_fold_rise));
  addsub #(.WIDTH(AW)) u_fold_fall (
    .CLK(CLK), .add(1'b0), .a(a_fold_fall), .b(b_fold_fall), .s(s_fold_fall));

  always_ff @(posedge CLK) begin
    phase_q     <= stream_drive.phase;
    duty_dly[0] <= stream_drive.duty;
    for (int i = 1; i < LAT + 2; i++) begin
      duty_dly[i] <= duty_dly[i-1];
    end

    b_phase <= {2'b00, phase_q};
    a_duty  <= {3'b000, duty_dly[0][W-1:1]};
    b_duty  <= {{(AW-1){1'b0}}, duty_dly[0][0]};

    a_rise <= s_phase;
    b_rise <= {3'b000, duty_dly[LAT+1][W-1:1]}; // duty delayed to meet s_phase
    a_fall <= s_phase;
    b_fall <= s_duty;

    a_fold_rise <= s_rise;
    if (s_rise[AW-1]) begin // below zero
      b_fold_rise   <= PERIOD;
      fold_rise_add <= 1'b1;
    end else if (s_rise >= PERIOD) begin
      b_fold_rise   <= PERIOD;
      fold_rise_add <= 1'b0;
    end else begin
      b_fold_rise   <= '0;
      fold_rise_add <= 1'b1;
    end
    a_fold_fall <= s_fall;
    b_fold_fall <= (s_fall >= PERIOD) ? PERIOD : '0; // fall never goes negative
  end

  assign store_en = (state == ST_RUN) && (fold_cnt > CNT_W'(LAT));

  always_ff @(posedge CLK) begin
    if (store_en) begin
      edge_buf[set_cnt[CH_W-1:0]] <= '{rise: s_fold_rise[W-1:0], fall: s_fold_fall[W-1:0]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= ST_WAIT;
      cnt      <= '0;
      lr_cnt   <= '0;
      fold_cnt <= '0;
      set_cnt  <= '0;
      done     <= 1'b0;
    end else begin
      case (state)
        ST_WAIT: begin
          done <= 1'b0;
          if (stream_valid) begin
            cnt      <= '0;
            lr_cnt   <= '0;
            fold_cnt <= '0;
            set_cnt  <= '0;
            state    <= ST_RUN;
          end
        end
        ST_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt > CNT_W'(LAT)) lr_cnt <= lr_cnt + 1'b1;
          if (lr_cnt > CNT_W'(LAT)) fold_cnt <= fold_cnt + 1'b1;
          if (store_en) begin
            set_cnt <= set_cnt + 1'b1;
            if (set_cnt == CNT_W'(`PWM_CHANNELS - 1)) state <= ST_DONE;
          end
        end
        default: begin // ST_DONE, table copied this cycle
          done  <= 1'b1;
          state <= ST_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < `PWM_CHANNELS; i++) edges[i] <= '0;
    end else if (state == ST_DONE) begin
      for (int i = 0; i < `PWM_CHANNELS; i++) edges[i] <= edge_buf[i];
    end
  end

  // the register file streams exactly one channel set per run
  stream_fits_run: assert property (@(posedge CLK) disable iff (!rst_n)
    (state == ST_RUN && cnt >= CNT_W'(`PWM_CHANNELS - 1)) |-> !stream_valid);

endmodule

`default_nettype wire

// File: src/addsub.sv
/*
  two-stage pipelined signed adder/subtractor
  operands and select registered, then the result
*/
`timescale 1ns/10ps
`default_nettype none

module addsub #(
  parameter int WIDTH = 11
) (
  input  var logic                    CLK,
  input  var logic                    add, // 1: a + b, 0: a - b
  input  var logic signed [WIDTH-1:0] a,
  input  var logic signed [WIDTH-1:0] b,
  output logic signed [WIDTH-1:0]     s
);

  logic signed [WIDTH-1:0] a_q, b_q;
  logic                    add_q;

  always_ff @(posedge CLK) begin
    a_q   <= a;
    b_q   <= b;
    add_q <= add;
    s     <= add_q ? a_q + b_q : a_q - b_q;
  end

endmodule

`default_nettype wire

// File: src/apb_pkg.sv
/*
  APB request and response structs
*/
`default_nettype none

package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: src/pwm_pkg.sv
/*
  PWM data types
  drive setting, edge pair, control word, register word views
*/
`default_nettype none
`include "pwm_settings.svh"

package pwm_pkg;

  typedef struct packed {
    logic [`PWM_WIDTH-1:0] duty;
    logic [`PWM_WIDTH-1:0] phase;
  } drive_t;

  typedef struct packed {
    logic [`PWM_WIDTH-1:0] rise;
    logic [`PWM_WIDTH-1:0] fall;
  } edge_t;

  typedef struct packed {
    logic [30:0] rsvd;
    logic        update; // write: commit, read: busy
  } ctrl_t;

  // channel register layout, duty in the upper half and phase in the lower
  typedef struct packed {
    logic [15-`PWM_WIDTH:0] pad_hi;
    logic [`PWM_WIDTH-1:0]  duty;
    logic [15-`PWM_WIDTH:0] pad_lo;
    logic [`PWM_WIDTH-1:0]  phase;
  } drive_word_t;

  typedef union packed {
    drive_word_t drv;
    ctrl_t       ctrl;
  } reg_word_u;

endpackage

`default_nettype wire

// File: include/pwm_settings.svh
/*
  build constants for the transducer PWM subsystem
  channel count, edge width, carrier period, adder latency
*/
`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

`define PWM_CHANNELS 8
`define PWM_WIDTH 9
`define PWM_PERIOD 512 // 2 ** PWM_WIDTH
`define PWM_ADDSUB_LATENCY 2

`endif
